/* design/ecc_drbg_pkg.sv */
// shared widths, mixing constants and sequencer states for the ecc randomness sequencer

package ecc_drbg_pkg;

    // ------------------------------
    // widths
    // ------------------------------

    // every key, seed, iv, message and output value is one word
    localparam int WORD_SIZE = 32;

    // generator counter, advanced by each next command
    localparam int CNT_SIZE = 4;

    // ------------------------------
    // generator constants
    // ------------------------------

    // all outputs are reduced below this modulus
    // one subtraction is enough since 2*GROUP_ORDER exceeds 2**WORD_SIZE
    localparam logic [WORD_SIZE-1:0] GROUP_ORDER = 32'hc7634d81;

    // one mixing round per clock
    localparam int MIX_ROUNDS = 8;

    // round counter width
    localparam int ROUND_CNT_SIZE = $clog2(MIX_ROUNDS);

    // odd multiplier that spreads the counter over the whole key word
    localparam logic [WORD_SIZE-1:0] MIX_MULT = 32'h9e3779b1;

    // additive constant used in every round
    localparam logic [WORD_SIZE-1:0] MIX_ADD = 32'h7f4a7c15;

    // left rotate amount per round
    localparam int MIX_ROT = 7;

    // ------------------------------
    // sequencer states
    // ------------------------------

    typedef enum logic [2:0] {
        IDLE_ST        = 3'd0,
        LAMBDA_ST      = 3'd1,
        SCALAR_RND_ST  = 3'd2,
        RND_DONE_ST    = 3'd3,
        MASKING_RND_ST = 3'd4,
        KEYGEN_ST      = 3'd5,
        SIGN_ST        = 3'd6,
        DONE_ST        = 3'd7
    } seq_state_e;

endpackage

/* design/drbg_core.sv */
// deterministic generator core with key and counter state, round mixing and modular reduction
`timescale 1ns/100ps

module drbg_core
    import ecc_drbg_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize,
    input  logic                 init_cmd,
    input  logic                 next_cmd,
    input  logic [WORD_SIZE-1:0] key,
    output logic                 busy,
    output logic                 valid,
    output logic [WORD_SIZE-1:0] result
);

    // ------------------------------
    // state
    // ------------------------------

    logic [WORD_SIZE-1:0]      key_reg;
    logic [CNT_SIZE-1:0]       cnt_reg;
    logic [ROUND_CNT_SIZE-1:0] round_cnt;
    logic [WORD_SIZE-1:0]      work_reg;
    logic [WORD_SIZE-1:0]      result_reg;

    // command side
    logic                      cmd;
    logic [WORD_SIZE-1:0]      key_next;
    logic [CNT_SIZE-1:0]       cnt_next;
    logic [WORD_SIZE-1:0]      cnt_word;
    logic [WORD_SIZE-1:0]      start_value;

    // round side
    logic                      last_round;
    logic [WORD_SIZE-1:0]      mixed;
    logic [WORD_SIZE-1:0]      reduced;

    // one round rotates left and xors in the value plus the round constant
    function automatic logic [WORD_SIZE-1:0] mix_round(input logic [WORD_SIZE-1:0] value);
        logic [WORD_SIZE-1:0] rotated;
        rotated = (value << MIX_ROT) | (value >> (WORD_SIZE - MIX_ROT));
        return rotated ^ (value + MIX_ADD);
    endfunction

    // ------------------------------
    // command decode
    // ------------------------------

    assign cmd = init_cmd | next_cmd;

    // init takes a fresh key and restarts the counter while next keeps the key
    assign key_next = init_cmd ? key : key_reg;
    assign cnt_next = init_cmd ? '0 : cnt_reg + CNT_SIZE'(1);

    // counter zero-extended before the multiply and product truncated to a word
    assign cnt_word    = {{(WORD_SIZE - CNT_SIZE){1'b0}}, cnt_next};
    assign start_value = key_next ^ (cnt_word * MIX_MULT);

    // ------------------------------
    // mixing and reduction
    // ------------------------------

    assign last_round = (round_cnt == ROUND_CNT_SIZE'(MIX_ROUNDS - 1));
    assign mixed      = mix_round(work_reg);

    // single compare-and-subtract keeps the output below the group order
    assign reduced = (mixed >= GROUP_ORDER) ? (mixed - GROUP_ORDER) : mixed;

    // control registers
    // valid rises with the last round 9 cycles after the strobe
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            key_reg   <= '0;
            cnt_reg   <= '0;
            round_cnt <= '0;
            busy      <= 1'b0;
            valid     <= 1'b0;
        end
        else if (zeroize)
        begin
            key_reg   <= '0;
            cnt_reg   <= '0;
            round_cnt <= '0;
            busy      <= 1'b0;
            valid     <= 1'b0;
        end
        else if (cmd)
        begin
            key_reg   <= key_next;
            cnt_reg   <= cnt_next;
            round_cnt <= '0;
            busy      <= 1'b1;
            valid     <= 1'b0;
        end
        else if (busy)
        begin
            round_cnt <= round_cnt + ROUND_CNT_SIZE'(1);
            if (last_round)
            begin
                busy  <= 1'b0;
                valid <= 1'b1;
            end
        end
        else
        begin
            // valid is a single-cycle strobe
            valid <= 1'b0;
        end
    end

    // working value and captured result
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            work_reg   <= '0;
            result_reg <= '0;
        end
        else if (zeroize)
        begin
            work_reg   <= '0;
            result_reg <= '0;
        end
        else if (cmd)
        begin
            work_reg <= start_value;
        end
        else if (busy)
        begin
            work_reg <= mixed;
            // result holds until the next command
            if (last_round)
                result_reg <= reduced;
        end
    end

    assign result = result_reg;

endmodule

/* design/ecc_drbg_sequencer.sv */
// mode-dependent sequencer that runs the generator for each random value and stores the results
`timescale 1ns/100ps

module ecc_drbg_sequencer
    import ecc_drbg_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize,
    input  logic                 keygen_sign,
    input  logic                 en,
    input  logic [WORD_SIZE-1:0] seed,
    input  logic [WORD_SIZE-1:0] privkey,
    input  logic [WORD_SIZE-1:0] iv,
    input  logic [WORD_SIZE-1:0] hashed_msg,
    input  logic                 valid,
    input  logic [WORD_SIZE-1:0] result,
    output logic                 ready,
    output logic                 init_cmd,
    output logic                 next_cmd,
    output logic [WORD_SIZE-1:0] key,
    output logic [WORD_SIZE-1:0] lambda,
    output logic [WORD_SIZE-1:0] scalar_rnd,
    output logic [WORD_SIZE-1:0] masking_rnd,
    output logic [WORD_SIZE-1:0] nonce
);

    seq_state_e state_reg;
    seq_state_e state_next;
    seq_state_e state_last;

    // high in the first cycle of every state
    logic first_round;

    logic [WORD_SIZE-1:0] lambda_reg;
    logic [WORD_SIZE-1:0] scalar_rnd_reg;
    logic [WORD_SIZE-1:0] masking_rnd_reg;
    logic [WORD_SIZE-1:0] nonce_reg;

    // ------------------------------
    // generator commands
    // ------------------------------

    assign first_round = (state_reg != state_last);

    // key source per step
    // iv steps share one key
    // sign nonce mixes privkey with the message hash
    always_comb
    begin
        case (state_reg)
            LAMBDA_ST:      key = iv;
            SCALAR_RND_ST:  key = iv;
            MASKING_RND_ST: key = iv;
            KEYGEN_ST:      key = seed;
            SIGN_ST:        key = privkey ^ hashed_msg;
            default:        key = '0;
        endcase
    end

    // first iv step restarts the generator and later iv steps continue it
    always_comb
    begin
        init_cmd = 1'b0;
        next_cmd = 1'b0;
        if (first_round)
        begin
            case (state_reg)
                LAMBDA_ST:      init_cmd = 1'b1;
                SCALAR_RND_ST:  next_cmd = 1'b1;
                MASKING_RND_ST: next_cmd = 1'b1;
                KEYGEN_ST:      init_cmd = 1'b1;
                SIGN_ST:        init_cmd = 1'b1;
                default:
                begin
                    init_cmd = 1'b0;
                    next_cmd = 1'b0;
                end
            endcase
        end
    end

    // ------------------------------
    // FSM
    // ------------------------------

    always_comb
    begin
        case (state_reg)
            IDLE_ST:        state_next = en ? LAMBDA_ST : IDLE_ST;
            LAMBDA_ST:      state_next = valid ? SCALAR_RND_ST : LAMBDA_ST;
            SCALAR_RND_ST:  state_next = valid ? RND_DONE_ST : SCALAR_RND_ST;
            // keygen_sign high selects sign mode
            RND_DONE_ST:    state_next = keygen_sign ? MASKING_RND_ST : KEYGEN_ST;
            MASKING_RND_ST: state_next = valid ? SIGN_ST : MASKING_RND_ST;
            KEYGEN_ST:      state_next = valid ? DONE_ST : KEYGEN_ST;
            SIGN_ST:        state_next = valid ? DONE_ST : SIGN_ST;
            DONE_ST:        state_next = IDLE_ST;
            default:        state_next = IDLE_ST;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            state_reg <= IDLE_ST;
        else if (zeroize)
            state_reg <= IDLE_ST;
        else
            state_reg <= state_next;
    end

    // previous state for entry detection
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            state_last <= IDLE_ST;
        else
            state_last <= state_reg;
    end

    // ------------------------------
    // result capture
    // ------------------------------

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            lambda_reg      <= '0;
            scalar_rnd_reg  <= '0;
            masking_rnd_reg <= '0;
            nonce_reg       <= '0;
        end
        else if (zeroize)
        begin
            lambda_reg      <= '0;
            scalar_rnd_reg  <= '0;
            masking_rnd_reg <= '0;
            nonce_reg       <= '0;
        end
        else if (valid)
        begin
            case (state_reg)
                LAMBDA_ST:      lambda_reg      <= result;
                SCALAR_RND_ST:  scalar_rnd_reg  <= result;
                MASKING_RND_ST: masking_rnd_reg <= result;
                KEYGEN_ST:      nonce_reg       <= result;
                SIGN_ST:        nonce_reg       <= result;
                default:        nonce_reg       <= nonce_reg;
            endcase
        end
    end

    assign lambda      = lambda_reg;
    assign scalar_rnd  = scalar_rnd_reg;
    assign masking_rnd = masking_rnd_reg;
    assign nonce       = nonce_reg;
    assign ready       = (state_reg == IDLE_ST);

endmodule

/* design/ecc_drbg_top.sv */
// top level of the randomness sequencer, joining the step FSM and the generator core
`timescale 1ns/100ps

module ecc_drbg_top
    import ecc_drbg_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 zeroize,
    input  logic                 keygen_sign,
    input  logic                 en,
    input  logic [WORD_SIZE-1:0] seed,
    input  logic [WORD_SIZE-1:0] privkey,
    input  logic [WORD_SIZE-1:0] iv,
    input  logic [WORD_SIZE-1:0] hashed_msg,
    output logic                 ready,
    output logic [WORD_SIZE-1:0] lambda,
    output logic [WORD_SIZE-1:0] scalar_rnd,
    output logic [WORD_SIZE-1:0] masking_rnd,
    output logic [WORD_SIZE-1:0] nonce
);

    // sequencer to core
    logic                 init_cmd;
    logic                 next_cmd;
    logic [WORD_SIZE-1:0] drbg_key;

    // core to sequencer
    logic                 drbg_valid;
    logic [WORD_SIZE-1:0] drbg_result;

    ecc_drbg_sequencer u_sequencer (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .keygen_sign (keygen_sign),
        .en          (en),
        .seed        (seed),
        .privkey     (privkey),
        .iv          (iv),
        .hashed_msg  (hashed_msg),
        .valid       (drbg_valid),
        .result      (drbg_result),
        .ready       (ready),
        .init_cmd    (init_cmd),
        .next_cmd    (next_cmd),
        .key         (drbg_key),
        .lambda      (lambda),
        .scalar_rnd  (scalar_rnd),
        .masking_rnd (masking_rnd),
        .nonce       (nonce)
    );

    // the sequencer paces itself on valid and leaves busy open
    drbg_core u_core (
        .clk      (clk),
        .reset_n  (reset_n),
        .zeroize  (zeroize),
        .init_cmd (init_cmd),
        .next_cmd (next_cmd),
        .key      (drbg_key),
        .busy     (),
        .valid    (drbg_valid),
        .result   (drbg_result)
    );

endmodule

/* testbench/ecc_drbg_properties.sv */
// concurrent protocol checks on the generator core, bound into drbg_core
`timescale 1ns/100ps

module ecc_drbg_properties
    import ecc_drbg_pkg::*;
(
    input logic                 clk,
    input logic                 reset_n,
    input logic                 zeroize,
    input logic                 init_cmd,
    input logic                 next_cmd,
    input logic                 busy,
    input logic                 valid,
    input logic [WORD_SIZE-1:0] result
);

    // running count of failed assertions
    int fail_count = 0;

    logic                cmd;
    // zeroize as sampled on the last MIX_ROUNDS+1 edges
    logic [MIX_ROUNDS:0] zeroize_hist;

    assign cmd = init_cmd | next_cmd;

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            zeroize_hist <= '0;
        else
            zeroize_hist <= {zeroize_hist[MIX_ROUNDS-1:0], zeroize};
    end

    // ------------------------------
    // a command not cut off by zeroize ends in valid
    a_valid_after_cmd: assert property (@(posedge clk) disable iff (!reset_n)
        ($past(cmd, MIX_ROUNDS + 1) && (zeroize_hist == '0)) |-> valid)
    else
    begin
        fail_count++;
        $error("valid missing %0d cycles after a command", MIX_ROUNDS + 1);
    end

    // and valid never comes at any other distance
    a_valid_only_after_cmd: assert property (@(posedge clk) disable iff (!reset_n)
        valid |-> $past(cmd, MIX_ROUNDS + 1))
    else
    begin
        fail_count++;
        $error("valid without a command %0d cycles before", MIX_ROUNDS + 1);
    end

    a_result_reduced: assert property (@(posedge clk) disable iff (!reset_n)
        valid |-> (result < GROUP_ORDER))
    else
    begin
        fail_count++;
        $error("result %h not below the group order", result);
    end

    a_cmd_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
        !(init_cmd && next_cmd))
    else
    begin
        fail_count++;
        $error("init and next commands high together");
    end

    // without back-pressure the sequencer must wait out a running generation
    a_no_cmd_when_busy: assert property (@(posedge clk) disable iff (!reset_n)
        busy |-> !cmd)
    else
    begin
        fail_count++;
        $error("command issued while the generator is busy");
    end

endmodule

/* testbench/tb_ecc_drbg.sv */
// testbench for the ecc randomness sequencer with a reference model of the generator
`timescale 1ns/100ps

module tb_ecc_drbg
    import ecc_drbg_pkg::*;
();

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 3;
    localparam int DRIVE_DELAY     = 10;
    localparam int NUM_RANDOM_RUNS = 20;
    // directed, random, en pulse and zeroize runs
    localparam int NUM_RUNS        = 2 + NUM_RANDOM_RUNS + 2 + 2;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * 6 * (MIX_ROUNDS + 4) + 100;

    logic clk;
    logic reset_n;
    logic zeroize;
    logic keygen_sign;
    logic en;
    logic [WORD_SIZE-1:0] seed;
    logic [WORD_SIZE-1:0] privkey;
    logic [WORD_SIZE-1:0] iv;
    logic [WORD_SIZE-1:0] hashed_msg;
    logic ready;
    logic [WORD_SIZE-1:0] lambda;
    logic [WORD_SIZE-1:0] scalar_rnd;
    logic [WORD_SIZE-1:0] masking_rnd;
    logic [WORD_SIZE-1:0] nonce;

    // expected outputs
    // masking_rnd carries over keygen runs
    logic [WORD_SIZE-1:0] exp_lambda = '0;
    logic [WORD_SIZE-1:0] exp_scalar = '0;
    logic [WORD_SIZE-1:0] exp_masking = '0;
    logic [WORD_SIZE-1:0] exp_nonce = '0;

    int    rng_seed = 32'h02abf566;
    int    error_count = 0;
    int    wrap_count = 0;
    int    test_count = 0;
    int    failed_tests = 0;
    int    test_start_errors;
    string test_name;

    ecc_drbg_top uut (.*);

    bind drbg_core ecc_drbg_properties u_props (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .init_cmd(init_cmd),
        .next_cmd(next_cmd), .busy(busy), .valid(valid), .result(result)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ------------------------------
    // reference model of the generator
    // ------------------------------

    function automatic logic [WORD_SIZE-1:0] drbg_model(input logic [WORD_SIZE-1:0] k,
                                                        input int c, output bit wrapped);
        logic [WORD_SIZE-1:0] v;
        logic [WORD_SIZE-1:0] cw;
        int                   r;
        cw = WORD_SIZE'(c);
        v  = k ^ (cw * MIX_MULT);
        for (r = 0; r < MIX_ROUNDS; r++)
            v = {v[WORD_SIZE-MIX_ROT-1:0], v[WORD_SIZE-1:WORD_SIZE-MIX_ROT]} ^ (v + MIX_ADD);
        wrapped = (v >= GROUP_ORDER);
        if (wrapped)
            v = v - GROUP_ORDER;
        return v;
    endfunction

    // model value that also counts the values needing the reduction
    function automatic logic [WORD_SIZE-1:0] expect_value(input logic [WORD_SIZE-1:0] k,
                                                          input int c);
        bit                   wrapped;
        logic [WORD_SIZE-1:0] v;
        v = drbg_model(k, c, wrapped);
        if (wrapped)
            wrap_count++;
        return v;
    endfunction

    function automatic int total_errors();
        return error_count + uut.u_core.u_props.fail_count;
    endfunction

    // ------------------------------
    // stimulus and checks
    // ------------------------------

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_word(input string name, input logic [WORD_SIZE-1:0] actual,
                              input logic [WORD_SIZE-1:0] expected);
        assert (actual === expected)
        else
        begin
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_outputs();
        assert (ready === 1'b1)
        else
        begin
            $display("ERROR at %0t: ready expected 1, got %b", $time, ready);
            error_count++;
        end
        check_word("lambda", lambda, exp_lambda);
        check_word("scalar_rnd", scalar_rnd, exp_scalar);
        check_word("masking_rnd", masking_rnd, exp_masking);
        check_word("nonce", nonce, exp_nonce);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_start_errors = total_errors();
        test_count++;
    endtask

    task automatic end_test();
        int n;
        n = total_errors() - test_start_errors;
        if (n == 0)
            $display("test %0d %s: ok", test_count, test_name);
        else
        begin
            $display("test %0d %s: %0d errors", test_count, test_name, n);
            failed_tests++;
        end
    endtask

    task automatic new_operands();
        seed       = $random(rng_seed);
        privkey    = $random(rng_seed);
        iv         = $random(rng_seed);
        hashed_msg = $random(rng_seed);
    endtask

    // accept one run and wait for ready with optional en pulses in between
    task automatic run_mode(input bit sign, input bit pulse_en);
        int cycles;
        cycles      = 0;
        keygen_sign = sign;
        en          = 1'b1;
        next_cycle();
        while (ready !== 1'b1)
        begin
            en = pulse_en && (cycles % 3 == 1);
            next_cycle();
            cycles++;
        end
        en = 1'b0;
    endtask

    task automatic run_and_check(input bit sign, input bit pulse_en);
        new_operands();
        exp_lambda = expect_value(iv, 0);
        exp_scalar = expect_value(iv, 1);
        if (sign)
        begin
            exp_masking = expect_value(iv, 2);
            exp_nonce   = expect_value(privkey ^ hashed_msg, 0);
        end
        else
            exp_nonce = expect_value(seed, 0);
        run_mode(sign, pulse_en);
        check_outputs();
    endtask

    // ------------------------------
    // test sequence
    // ------------------------------

    initial
    begin
        int r;
        int i;
        int cycles;
        reset_n     = 1'b0;
        zeroize     = 1'b0;
        keygen_sign = 1'b0;
        en          = 1'b0;
        seed        = '0;
        privkey     = '0;
        iv          = '0;
        hashed_msg  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset_n = 1'b1;
        next_cycle();

        begin_test("reset state");
        check_outputs();
        end_test();

        begin_test("keygen run");
        run_and_check(1'b0, 1'b0);
        end_test();

        begin_test("sign run");
        run_and_check(1'b1, 1'b0);
        end_test();

        begin_test("random mixed runs");
        wrap_count = 0;
        for (i = 0; i < NUM_RANDOM_RUNS; i++)
        begin
            r = $random(rng_seed);
            run_and_check(r[0], 1'b0);
        end
        assert (wrap_count > 0)
        else
        begin
            $display("no random value needed the reduction step");
            error_count++;
        end
        end_test();

        begin_test("en pulses during runs");
        run_and_check(1'b0, 1'b1);
        run_and_check(1'b1, 1'b1);
        end_test();

        begin_test("zeroize mid-run");
        new_operands();
        keygen_sign = 1'b1;
        en          = 1'b1;
        next_cycle();
        en = 1'b0;
        // lands inside the scalar_rnd step
        repeat (15) next_cycle();
        assert (ready === 1'b0)
        else
        begin
            $display("run was already over before zeroize");
            error_count++;
        end
        zeroize = 1'b1;
        next_cycle();
        zeroize = 1'b0;
        cycles  = 1;
        while (ready !== 1'b1 && cycles < 2)
        begin
            next_cycle();
            cycles++;
        end
        exp_lambda  = '0;
        exp_scalar  = '0;
        exp_masking = '0;
        exp_nonce   = '0;
        check_outputs();
        run_and_check(1'b1, 1'b0);
        end_test();

        $display("tests: %0d run, %0d failed, %0d value errors, %0d assertion failures",
                 test_count, failed_tests, error_count, uut.u_core.u_props.fail_count);
        if (total_errors() == 0 && failed_tests == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

    // watchdog sized from the number of runs and stages
    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: ready did not return within %0d cycles", WATCHDOG_CYCLES);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* filelist.f */
design/ecc_drbg_pkg.sv
design/drbg_core.sv
design/ecc_drbg_sequencer.sv
design/ecc_drbg_top.sv
testbench/ecc_drbg_properties.sv
testbench/tb_ecc_drbg.sv

/* Makefile */
# Verilator build and run of the ecc randomness sequencer testbench

VERILATOR ?= verilator
TOP       ?= tb_ecc_drbg
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0
SIM_FLAGS ?= +verilator+error+limit+1000
FAIL_MSG  ?= >>> FAIL
PASS_MSG  ?= >>> PASS

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: build
	@./$(BUILD_DIR)/V$(TOP) $(SIM_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -F -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -F -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
